// ==== flist.f ====
logic/fetch_pkg.sv
logic/channel_file.sv
logic/pending_write_counter.sv
logic/fetch_control.sv
logic/fetch_substage.sv
logic/skid_buffer.sv
logic/operand_fetch.sv
sim/operand_fetch_asserts.sv
sim/operand_fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module operand_fetch_tb -f flist.f \
	-o operand_fetch_sim || { echo "build failed"; exit 1; }
./obj_dir/operand_fetch_sim | tee /dev/stderr | grep -q "^Simulation passed$" \
	&& echo "run passed" || { echo "run failed"; exit 1; }

// ==== sim/operand_fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_tb
	import fetch_pkg::*;
;

	localparam int NUM_INSTR  = 400;
	localparam int WAIT_LIMIT = 1000;    // cycles
	localparam int RUN_LIMIT  = 40000;   // cycles for the writeback loop

	typedef struct packed {
		tag_t       tag;
		chan_addr_t dest;
		logic       writes_channel;
		data_t      arg_a;
		data_t      arg_b;
		data_t      arg_c;
		data_t      write_value;
	} expected_t;

	typedef struct packed {
		chan_addr_t addr;
		data_t      value;
		int         due;
	} pending_write_t;

	logic        clk;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	instr_t      in_instr;
	logic        out_valid;
	logic        out_ready;
	fetched_t    out_fetched;
	chan_write_t chan_write;

	data_t          model_chan [N_CHANNELS];   // value after every generated write
	expected_t      expected_q[$];
	pending_write_t write_q[$];
	commit_id_t     next_commit = '0;
	int             received    = 0;
	int             cycle       = 0;

	operand_fetch #(.pending_width(4)) operand_fetch_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_fetched(out_fetched),
		.chan_write(chan_write)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			stop_with_failure($sformatf("[FAIL] %s: got %h, expected %h", name, got, want));
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic data_t expected_operand(input instr_t instr, input operand_sel_t sel);
		data_t value;
		value = '0;
		if (sel.needed && sel.is_reg) begin
			case (sel.src)
				4'd0: value = instr.register_0;
				4'd1: value = instr.register_1;
				4'd3: value[DATA_WIDTH - 2] = 1'b1;   // quarter scale
				4'd4: value[DATA_WIDTH - 1] = 1'b1;   // half scale
				default: value = '0;
			endcase
		end else if (sel.needed) begin
			value = model_chan[sel.src];
		end
		return value;
	endfunction

	// channels 0..2 are favoured so reads and writes collide
	function automatic chan_addr_t random_channel();
		if ($urandom_range(0, 3) != 0)
			return chan_addr_t'($urandom_range(0, 2));
		return chan_addr_t'($urandom_range(0, 15));
	endfunction

	function automatic operand_sel_t random_selector();
		operand_sel_t sel;
		sel.needed = ($urandom_range(0, 7) != 0);
		sel.is_reg = ($urandom_range(0, 9) < 4);
		if (sel.is_reg)
			sel.src = chan_addr_t'($urandom_range(0, 7));   // includes unused codes
		else
			sel.src = random_channel();
		return sel;
	endfunction

	task automatic make_instruction(output instr_t instr);
		expected_t exp;
		instr.tag            = tag_t'($urandom());
		instr.dest           = random_channel();
		instr.writes_channel = ($urandom_range(0, 9) < 6);
		instr.register_0     = data_t'($urandom());
		instr.register_1     = data_t'($urandom());
		instr.op_a           = random_selector();
		instr.op_b           = random_selector();
		instr.op_c           = random_selector();
		exp.tag            = instr.tag;
		exp.dest           = instr.dest;
		exp.writes_channel = instr.writes_channel;
		exp.arg_a          = expected_operand(instr, instr.op_a);
		exp.arg_b          = expected_operand(instr, instr.op_b);
		exp.arg_c          = expected_operand(instr, instr.op_c);
		exp.write_value    = data_t'($urandom());
		if (instr.writes_channel)
			model_chan[instr.dest] = exp.write_value;   // younger instructions see this
		expected_q.push_back(exp);
	endtask

	//////////////////////////////////////////////////
	// stimulus, output checks and writeback
	//////////////////////////////////////////////////

	task automatic drive_inputs();
		instr_t instr;
		int     gap;
		int     waited;
		for (int n = 0; n < NUM_INSTR; n++) begin
			gap = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
			repeat (gap) @(negedge clk);
			make_instruction(instr);
			in_instr = instr;
			in_valid = 1'b1;
			waited   = 0;
			#1;
			while (!in_ready) begin
				waited++;
				if (waited > WAIT_LIMIT)
					stop_with_failure("timed out waiting for in_ready");
				@(negedge clk);
				#1;
			end
			@(negedge clk);   // accepted on the edge just passed
			in_valid = 1'b0;
		end
	endtask

	task automatic watch_outputs();
		expected_t exp;
		int        idle;
		idle = 0;
		while (received < NUM_INSTR) begin
			@(negedge clk);
			out_ready = ($urandom_range(0, 3) != 0);
			#1;
			if (out_valid && out_ready) begin
				idle = 0;
				if (expected_q.size() == 0)
					stop_with_failure("an output appeared with no instruction outstanding");
				exp = expected_q.pop_front();
				check("out_fetched.tag", 32'(out_fetched.tag), 32'(exp.tag));
				check("out_fetched.dest", 32'(out_fetched.dest), 32'(exp.dest));
				check("out_fetched.writes_channel", 32'(out_fetched.writes_channel),
					32'(exp.writes_channel));
				check("out_fetched.arg_a", 32'(out_fetched.arg_a), 32'(exp.arg_a));
				check("out_fetched.arg_b", 32'(out_fetched.arg_b), 32'(exp.arg_b));
				check("out_fetched.arg_c", 32'(out_fetched.arg_c), 32'(exp.arg_c));
				if (exp.writes_channel) begin
					check("out_fetched.commit_id", 32'(out_fetched.commit_id), 32'(next_commit));
					next_commit = next_commit + 1'b1;
					// earliest write lands one cycle after the instruction leaves
					write_q.push_back('{addr: exp.dest, value: exp.write_value,
						due: cycle + 1 + int'($urandom_range(0, 5))});
				end
				received++;
			end else begin
				idle++;
				if (idle > WAIT_LIMIT)
					stop_with_failure("timed out waiting for an output");
			end
		end
	endtask

	task automatic perform_writes();
		pending_write_t wr;
		int             loops;
		loops = 0;
		while (received < NUM_INSTR || write_q.size() != 0) begin
			loops++;
			if (loops > RUN_LIMIT)
				stop_with_failure("timed out before all channel writes were done");
			@(negedge clk);
			chan_write = '0;
			if (write_q.size() != 0 && write_q[0].due <= cycle) begin
				wr = write_q.pop_front();
				chan_write.valid = 1'b1;
				chan_write.addr  = wr.addr;
				chan_write.value = wr.value;
			end
		end
		@(negedge clk);
		chan_write = '0;
	endtask

	initial begin
		void'($urandom(32'h16c8));
		clk        = 1'b0;
		reset      = 1'b1;
		in_valid   = 1'b0;
		in_instr   = '0;
		out_ready  = 1'b0;
		chan_write = '0;
		for (int i = 0; i < N_CHANNELS; i++)
			model_chan[i] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check("out_valid", 32'(out_valid), 32'd0);
		check("in_ready", 32'(in_ready), 32'd1);
		fork
			drive_inputs();
			watch_outputs();
			perform_writes();
		join
		for (int n = 0; n < 8; n++) begin
			@(negedge clk);
			#1;
			check("out_valid", 32'(out_valid), 32'd0);   // nothing beyond the last instruction
		end
		if (operand_fetch_i.fetch_asserts.failures == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_with_failure("one or more bound assertions failed");
		end
	end

endmodule

`default_nettype wire

// ==== sim/operand_fetch_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_asserts
	import fetch_pkg::*;
(
	input wire              clk,
	input wire              reset,
	input wire              out_valid,
	input wire              out_ready,
	input wire fetched_t    out_fetched,
	input wire chan_write_t chan_write
);

	int reset_fails = 0;
	int hold_fails  = 0;
	int write_fails = 0;
	int failures;

	assign failures = reset_fails + hold_fails + write_fails;   // read by the testbench

	quiet_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
	else begin
		$error("out_valid high in the cycle after reset");
		reset_fails++;
	end

	// a stalled output keeps its word
	stalled_output_held: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_fetched))
	else begin
		$error("stalled output dropped or changed");
		hold_fails++;
	end

	no_write_in_reset: assert property (@(posedge clk) reset |-> !chan_write.valid)
	else begin
		$error("channel write during reset");
		write_fails++;
	end

endmodule

bind operand_fetch operand_fetch_asserts fetch_asserts (
	.clk(clk),
	.reset(reset),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_fetched(out_fetched),
	.chan_write(chan_write)
);

`default_nettype wire

// ==== logic/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch
	import fetch_pkg::*;
#(
	parameter int pending_width = 4
) (
	input  wire              clk,
	input  wire              reset,

	input  wire              in_valid,
	output logic             in_ready,
	input  wire instr_t      in_instr,

	output logic             out_valid,
	input  wire              out_ready,
	output fetched_t         out_fetched,

	input  wire chan_write_t chan_write
);

	stage_word_t first_word;
	stage_word_t word_a;
	stage_word_t word_b;
	stage_word_t word_c;
	fetched_t    last_fetched;

	logic valid_a;
	logic valid_b;
	logic valid_c;
	logic ready_b;
	logic ready_c;
	logic ready_skid;

	chan_addr_t addr_a;
	chan_addr_t addr_b;
	chan_addr_t addr_c;
	data_t      read_a;
	data_t      read_b;
	data_t      read_c;

	assign first_word = '{instr: in_instr, commit_id: '0, arg_a: '0, arg_b: '0, arg_c: '0};

	//////////////////////////////////////////////////
	// substages, one operand each
	//////////////////////////////////////////////////

	fetch_substage #(.operand_index(0), .pending_width(pending_width)) fetch_a (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_word(first_word),
		.out_valid(valid_a), .out_ready(ready_b), .out_word(word_a),
		.chan_write(chan_write), .chan_read_addr(addr_a), .chan_read(read_a)
	);

	fetch_substage #(.operand_index(1), .pending_width(pending_width)) fetch_b (
		.clk(clk), .reset(reset),
		.in_valid(valid_a), .in_ready(ready_b), .in_word(word_a),
		.out_valid(valid_b), .out_ready(ready_c), .out_word(word_b),
		.chan_write(chan_write), .chan_read_addr(addr_b), .chan_read(read_b)
	);

	fetch_substage #(.operand_index(2), .pending_width(pending_width)) fetch_c (
		.clk(clk), .reset(reset),
		.in_valid(valid_b), .in_ready(ready_c), .in_word(word_b),
		.out_valid(valid_c), .out_ready(ready_skid), .out_word(word_c),
		.chan_write(chan_write), .chan_read_addr(addr_c), .chan_read(read_c)
	);

	channel_file channels (
		.clk(clk), .reset(reset),
		.chan_write(chan_write),
		.read_addr_a(addr_a), .read_addr_b(addr_b), .read_addr_c(addr_c),
		.read_a(read_a), .read_b(read_b), .read_c(read_c)
	);

	// drop the selectors and registers, keep what downstream needs
	assign last_fetched = '{
		tag:            word_c.instr.tag,
		dest:           word_c.instr.dest,
		writes_channel: word_c.instr.writes_channel,
		commit_id:      word_c.commit_id,
		arg_a:          word_c.arg_a,
		arg_b:          word_c.arg_b,
		arg_c:          word_c.arg_c
	};

	skid_buffer skid (
		.clk(clk), .reset(reset),
		.in_valid(valid_c), .in_ready(ready_skid), .in_data(last_fetched),
		.out_valid(out_valid), .out_ready(out_ready), .out_data(out_fetched)
	);

endmodule

`default_nettype wire

// ==== logic/skid_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module skid_buffer
	import fetch_pkg::*;
(
	input  wire           clk,
	input  wire           reset,

	input  wire           in_valid,
	output logic          in_ready,
	input  wire fetched_t in_data,

	output logic          out_valid,
	input  wire           out_ready,
	output fetched_t      out_data
);

	fetched_t skid_data;
	logic     skid_valid;
	logic     main_free;
	logic     take_in;

	assign in_ready  = ~skid_valid;   // straight from a flop
	assign take_in   = in_valid & in_ready;
	assign main_free = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_free) begin
			out_valid  <= skid_valid | take_in;
			skid_valid <= 1'b0;
		end else if (take_in) begin
			skid_valid <= 1'b1;   // main is stuck, park it
		end
	end

	always_ff @(posedge clk) begin
		if (main_free)
			out_data <= skid_valid ? skid_data : in_data;
		else if (take_in)
			skid_data <= in_data;
	end

endmodule

`default_nettype wire

// ==== logic/fetch_substage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_substage
	import fetch_pkg::*;
#(
	parameter int operand_index = 0,
	parameter int pending_width = 4
) (
	input  wire              clk,
	input  wire              reset,

	input  wire              in_valid,
	output logic             in_ready,
	input  wire stage_word_t in_word,

	output logic             out_valid,
	input  wire              out_ready,
	output stage_word_t      out_word,

	input  wire chan_write_t chan_write,
	output chan_addr_t       chan_read_addr,
	input  wire data_t       chan_read
);

	fetch_state_t state;
	stage_word_t  busy_word;
	stage_word_t  live_word;
	stage_word_t  next_word;
	operand_sel_t sel;
	data_t        reg_value;
	data_t        operand;
	commit_id_t   commit_count;

	logic pending_zero;
	logic pending_one;
	logic bypass_hit;
	logic resolved;
	logic needs_stall;
	logic capture_direct;
	logic capture_latched;
	logic send;

	assign live_word = (state == FETCH_BUSY) ? busy_word : in_word;

	always_comb begin
		case (operand_index)
			0:       sel = live_word.instr.op_a;
			1:       sel = live_word.instr.op_b;
			default: sel = live_word.instr.op_c;
		endcase
	end

	assign chan_read_addr = sel.src;

	always_comb begin
		case (sel.src)
			SRC_REG0:    reg_value = live_word.instr.register_0;
			SRC_REG1:    reg_value = live_word.instr.register_1;
			SRC_QUARTER: reg_value = SCALE_QUARTER;
			SRC_HALF:    reg_value = SCALE_HALF;
			default:     reg_value = '0;
		endcase
	end

	// last older write landing right now is forwarded
	assign bypass_hit  = chan_write.valid & (chan_write.addr == sel.src) & pending_one;
	assign resolved    = ~sel.needed | sel.is_reg | pending_zero | bypass_hit;
	assign needs_stall = ~resolved;

	always_comb begin
		if (!sel.needed)
			operand = '0;
		else if (sel.is_reg)
			operand = reg_value;
		else if (pending_zero)
			operand = chan_read;
		else
			operand = chan_write.value;
	end

	always_comb begin
		next_word = live_word;
		case (operand_index)
			0: next_word.arg_a = operand;
			1: next_word.arg_b = operand;
			default: begin
				next_word.arg_c     = operand;
				next_word.commit_id = commit_count;
			end
		endcase
	end

	assign send = capture_direct | capture_latched;

	always_ff @(posedge clk) begin
		if (in_valid && in_ready && needs_stall)
			busy_word <= in_word;
		if (send)
			out_word <= next_word;
	end

	always_ff @(posedge clk) begin
		if (reset)
			commit_count <= '0;
		else if (operand_index == 2 && send && live_word.instr.writes_channel)
			commit_count <= commit_count + 1'b1;
	end

	fetch_control control (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_ready(out_ready),
		.needs_stall(needs_stall),
		.resolved(resolved),
		.state(state),
		.capture_direct(capture_direct),
		.capture_latched(capture_latched),
		.out_valid(out_valid)
	);

	pending_write_counter #(.pending_width(pending_width)) pending (
		.clk(clk),
		.reset(reset),
		.issue(send & live_word.instr.writes_channel),
		.issue_addr(live_word.instr.dest),
		.chan_write(chan_write),
		.query_addr(sel.src),
		.pending_zero(pending_zero),
		.pending_one(pending_one)
	);

endmodule

`default_nettype wire

// ==== logic/fetch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_control
	import fetch_pkg::*;
(
	input  wire   clk,
	input  wire   reset,

	input  wire   in_valid,
	output logic  in_ready,
	input  wire   out_ready,

	input  wire   needs_stall,
	input  wire   resolved,

	output fetch_state_t state,
	output logic  capture_direct,
	output logic  capture_latched,
	output logic  out_valid
);

	logic out_free;
	logic take_in;

	assign out_free = ~out_valid | out_ready;   // output register empty or drained now
	assign in_ready = (state == FETCH_IDLE) & out_free;
	assign take_in  = in_valid & in_ready;

	assign capture_direct  = take_in & ~needs_stall;
	assign capture_latched = (state == FETCH_BUSY) & resolved & out_free;

	//////////////////////////////////////////////////
	// idle/busy state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH_IDLE;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (take_in && needs_stall)
						state <= FETCH_BUSY;   // hold the word until its operand lands
				end
				FETCH_BUSY: begin
					if (capture_latched)
						state <= FETCH_IDLE;
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output valid
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else if (capture_direct || capture_latched)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== logic/pending_write_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pending_write_counter
	import fetch_pkg::*;
#(
	parameter int pending_width = 4
) (
	input  wire              clk,
	input  wire              reset,

	input  wire              issue,
	input  wire chan_addr_t  issue_addr,

	input  wire chan_write_t chan_write,

	input  wire chan_addr_t  query_addr,
	output logic             pending_zero,
	output logic             pending_one
);

	logic [pending_width - 1 : 0] count [N_CHANNELS];
	logic [N_CHANNELS - 1 : 0] busy;   // count != 0, kept as a flop
	logic [N_CHANNELS - 1 : 0] inc;
	logic [N_CHANNELS - 1 : 0] dec;

	always_comb begin
		for (int i = 0; i < N_CHANNELS; i++) begin
			inc[i] = issue && (issue_addr == chan_addr_t'(i));
			dec[i] = chan_write.valid && (chan_write.addr == chan_addr_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				count[i] <= '0;
				busy[i]  <= 1'b0;
			end
		end else begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				case ({inc[i], dec[i]})
					2'b10: begin
						count[i] <= count[i] + 1'b1;
						busy[i]  <= 1'b1;
					end
					2'b01: begin
						if (busy[i]) begin   // stray writes on an idle channel are ignored
							count[i] <= count[i] - 1'b1;
							busy[i]  <= (count[i] != 1);
						end
					end
					default: ;   // none, or issue and write cancel
				endcase
			end
		end
	end

	assign pending_zero = ~busy[query_addr];
	assign pending_one  = (count[query_addr] == 1);

endmodule

`default_nettype wire

// ==== logic/channel_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_file
	import fetch_pkg::*;
(
	input  wire         clk,
	input  wire         reset,

	input  wire chan_write_t chan_write,

	input  wire chan_addr_t  read_addr_a,
	input  wire chan_addr_t  read_addr_b,
	input  wire chan_addr_t  read_addr_c,

	output data_t       read_a,
	output data_t       read_b,
	output data_t       read_c
);

	data_t channels [N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_CHANNELS; i++)
				channels[i] <= '0;
		end else if (chan_write.valid) begin
			channels[chan_write.addr] <= chan_write.value;
		end
	end

	// one read port per substage
	assign read_a = channels[read_addr_a];
	assign read_b = channels[read_addr_b];
	assign read_c = channels[read_addr_c];

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	localparam int DATA_WIDTH      = 16;
	localparam int N_CHANNELS      = 16;
	localparam int COMMIT_ID_WIDTH = 6;

	typedef logic signed [DATA_WIDTH - 1 : 0] data_t;
	typedef logic [3 : 0] chan_addr_t;
	typedef logic [COMMIT_ID_WIDTH - 1 : 0] commit_id_t;
	typedef logic [7 : 0] tag_t;

	// register source codes, anything else reads as zero
	localparam chan_addr_t SRC_REG0    = 4'd0;
	localparam chan_addr_t SRC_REG1    = 4'd1;
	localparam chan_addr_t SRC_QUARTER = 4'd3;
	localparam chan_addr_t SRC_HALF    = 4'd4;

	localparam data_t SCALE_QUARTER = data_t'({2'b01, {(DATA_WIDTH - 2){1'b0}}});
	localparam data_t SCALE_HALF    = data_t'({1'b1, {(DATA_WIDTH - 1){1'b0}}});

	typedef struct packed {
		logic       needed;
		logic       is_reg;
		chan_addr_t src;
	} operand_sel_t;

	typedef struct packed {
		tag_t         tag;
		chan_addr_t   dest;
		logic         writes_channel;
		data_t        register_0;
		data_t        register_1;
		operand_sel_t op_a;
		operand_sel_t op_b;
		operand_sel_t op_c;
	} instr_t;

	// commit_id is only filled in by the last substage
	typedef struct packed {
		instr_t     instr;
		commit_id_t commit_id;
		data_t      arg_a;
		data_t      arg_b;
		data_t      arg_c;
	} stage_word_t;

	typedef struct packed {
		tag_t       tag;
		chan_addr_t dest;
		logic       writes_channel;
		commit_id_t commit_id;
		data_t      arg_a;
		data_t      arg_b;
		data_t      arg_c;
	} fetched_t;

	typedef struct packed {
		logic       valid;
		chan_addr_t addr;
		data_t      value;
	} chan_write_t;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_BUSY
	} fetch_state_t;

endpackage

`default_nettype wire
